/* logic/vrx_pkg.sv */
package vrx_pkg;

	// --------------------------------------------------
	// Header values a frame must carry to be accepted
	// --------------------------------------------------
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IP_VER_IHL    = 8'h45;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
	// Station 0 address, station id is added to the last octet
	localparam logic [31:0] IPV4_DST_BASE = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [15:0] UDP_DST_PORT  = 16'd12345;

	// --------------------------------------------------
	// Byte offsets, counted from first byte with rx_dv
	// --------------------------------------------------
	localparam logic [10:0] OFS_ETH_TYPE      = 11'd20;
	localparam logic [10:0] OFS_IP_VER        = 11'd22;
	localparam logic [10:0] OFS_IP_PROTO      = 11'd31;
	localparam logic [10:0] OFS_IP_DST        = 11'd38;
	localparam logic [10:0] OFS_UDP_DST       = 11'd44;
	localparam logic [10:0] OFS_INFO          = 11'd50;
	localparam logic [10:0] OFS_LINE_LO       = 11'd51;
	localparam logic [10:0] OFS_LINE_HI       = 11'd52;
	// Last byte of the video region
	localparam logic [10:0] OFS_VIDEO_END     = 11'd1332;
	// First byte past the aux region of a vidax frame
	localparam logic [10:0] OFS_VIDAX_AUX_END = 11'd1382;

	// Output word widths
	localparam int VIDEO_WORD_W = 29;
	localparam int AUX_WORD_W   = 24;

	// Aux block layout
	localparam int AUX_SAMPLES = 32;
	localparam int AUX_CNT_W   = $clog2(AUX_SAMPLES);

	// Packet-info byte at OFS_INFO
	typedef enum logic [7:0] {
		kind_video = 8'd0,
		kind_audio = 8'd1,
		kind_vidax = 8'd2
	} pkt_kind_t;

	// Aux unpacker states
	typedef enum logic {
		aux_tag,
		aux_samples
	} aux_state_t;

endpackage

/* logic/vrx_payload_if.sv */
`timescale 1ns/1ps

// Byte stream plus region levels, from header filter to payload units
interface vrx_payload_if;

	// Raw GMII byte of the current cycle
	logic [7:0]  byte_d;

	// Region levels, aligned with byte_d
	logic        video_on;
	logic        aux_on;

	// Line info from bytes 51 and 52
	logic [10:0] line_no;
	logic        x_lsb;

	modport source (
		output byte_d, video_on, aux_on, line_no, x_lsb
	);

	modport sink (
		input byte_d, video_on, aux_on, line_no, x_lsb
	);

endinterface

/* logic/udp_hdr_filter.sv */
`timescale 1ns/1ps

module udp_hdr_filter (
	input  logic       clk125,
	input  logic       sys_rst,
	input  logic       id,
	input  logic       rx_dv,
	input  logic [7:0] rxd,
	output logic       packet_en,
	vrx_payload_if.source pl,
	input  logic       aux_done
);
	import vrx_pkg::*;

	logic [10:0] rx_count;
	logic [15:0] eth_type;
	logic [7:0]  ip_ver;
	logic [7:0]  ip_proto;
	logic [31:0] ip_dst;
	logic [15:0] udp_dst;
	logic [31:0] dst_expect;
	logic        hdr_match;
	pkt_kind_t   kind_q;
	pkt_kind_t   kind_in;
	logic        video_act;
	logic        aux_act;
	logic [10:0] line_q;
	logic        x_q;

	// --------------------------------------------------
	// Header field capture
	// --------------------------------------------------
	// Every field is rewritten before byte 50 of each frame
	always_ff @(posedge clk125) begin
		if (rx_dv) begin
			case (rx_count)
				OFS_ETH_TYPE:         eth_type[15:8] <= rxd;
				OFS_ETH_TYPE + 11'd1: eth_type[7:0]  <= rxd;
				OFS_IP_VER:           ip_ver         <= rxd;
				OFS_IP_PROTO:         ip_proto       <= rxd;
				OFS_IP_DST:           ip_dst[31:24]  <= rxd;
				OFS_IP_DST + 11'd1:   ip_dst[23:16]  <= rxd;
				OFS_IP_DST + 11'd2:   ip_dst[15:8]   <= rxd;
				OFS_IP_DST + 11'd3:   ip_dst[7:0]    <= rxd;
				OFS_UDP_DST:          udp_dst[15:8]  <= rxd;
				OFS_UDP_DST + 11'd1:  udp_dst[7:0]   <= rxd;
				OFS_LINE_LO:          line_q[7:0]    <= rxd;
				OFS_LINE_HI: begin
					line_q[10:8] <= rxd[2:0];
					x_q          <= rxd[4];
				end
				default: ;
			endcase
		end
	end

	// Station id selects .1 or .2
	assign dst_expect = IPV4_DST_BASE + {31'd0, id};

	assign hdr_match = (eth_type == ETH_TYPE_IPV4) &&
	                   (ip_ver == IP_VER_IHL) &&
	                   (ip_proto == IP_PROTO_UDP) &&
	                   (ip_dst == dst_expect) &&
	                   (udp_dst == UDP_DST_PORT);

	assign kind_in = pkt_kind_t'(rxd);

	// --------------------------------------------------
	// Byte count and payload regions
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			rx_count  <= 11'd0;
			packet_en <= 1'b0;
			video_act <= 1'b0;
			aux_act   <= 1'b0;
			kind_q    <= kind_video;
		end else if (!rx_dv) begin
			// End of frame, early or not
			rx_count  <= 11'd0;
			packet_en <= 1'b0;
			video_act <= 1'b0;
			aux_act   <= 1'b0;
		end else begin
			// Saturate so oversized frames cannot re-hit the offsets
			if (rx_count != 11'h7ff)
				rx_count <= rx_count + 11'd1;

			if (rx_count == OFS_INFO && hdr_match) begin
				kind_q <= kind_in;
				case (kind_in)
					kind_video, kind_vidax: packet_en <= 1'b1;
					kind_audio:             aux_act   <= 1'b1;
					default: ;
				endcase
			end

			// Video starts after the two line bytes
			if (rx_count == OFS_LINE_HI && packet_en)
				video_act <= 1'b1;

			if (rx_count == OFS_VIDEO_END) begin
				packet_en <= 1'b0;
				video_act <= 1'b0;
				if (packet_en && kind_q == kind_vidax)
					aux_act <= 1'b1;
			end

			// Vidax aux tail is a fixed window
			if (rx_count == OFS_VIDAX_AUX_END - 11'd1 && kind_q == kind_vidax)
				aux_act <= 1'b0;

			if (aux_done)
				aux_act <= 1'b0;
		end
	end

	// Levels follow rx_dv so a cut frame hands on no stale byte
	assign pl.byte_d   = rxd;
	assign pl.video_on = video_act & rx_dv;
	assign pl.aux_on   = aux_act & rx_dv;
	assign pl.line_no  = line_q;
	assign pl.x_lsb    = x_q;

	// The two payload units must never see the same byte
	a_regions_exclusive: assert property (
		@(posedge clk125) disable iff (sys_rst)
		!(pl.video_on && pl.aux_on)
	);

endmodule

/* logic/video_word_packer.sv */
`timescale 1ns/1ps

module video_word_packer (
	input  logic clk125,
	input  logic sys_rst,
	vrx_payload_if.sink pl,
	output logic [vrx_pkg::VIDEO_WORD_W-1:0] datain,
	output logic recv_en
);

	// Which byte of the pair is on the bus
	typedef enum logic {
		ph_first,
		ph_second
	} phase_t;

	phase_t     phase;
	logic [7:0] first_byte;

	// --------------------------------------------------
	// Pair phase and write strobe
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			phase   <= ph_first;
			recv_en <= 1'b0;
		end else begin
			recv_en <= 1'b0;
			if (pl.video_on) begin
				if (phase == ph_first) begin
					phase <= ph_second;
				end else begin
					phase   <= ph_first;
					recv_en <= 1'b1;
				end
			end else begin
				// Realign on every new region
				phase <= ph_first;
			end
		end
	end

	// --------------------------------------------------
	// Word assembly
	// --------------------------------------------------
	// Hold the first byte until its partner arrives
	always_ff @(posedge clk125) begin
		if (pl.video_on && phase == ph_first)
			first_byte <= pl.byte_d;
	end

	// Word is only updated on the second byte, so it holds between strobes
	always_ff @(posedge clk125) begin
		if (pl.video_on && phase == ph_second) begin
			datain <= {1'b0, pl.x_lsb, pl.line_no, first_byte, pl.byte_d};
		end
	end

	// Every word of one region carries the same line tag
	a_line_stable: assert property (
		@(posedge clk125) disable iff (sys_rst)
		pl.video_on && $past(pl.video_on) |-> $stable(pl.line_no) && $stable(pl.x_lsb)
	);

endmodule

/* logic/aux_sample_unpacker.sv */
`timescale 1ns/1ps

module aux_sample_unpacker (
	input  logic clk125,
	input  logic sys_rst,
	vrx_payload_if.sink pl,
	output logic [vrx_pkg::AUX_WORD_W-1:0] aux_data_in,
	output logic aux_wr_en,
	output logic aux_done
);
	import vrx_pkg::*;

	aux_state_t           state;
	logic                 tag_cnt;
	logic [AUX_CNT_W-1:0] smp_cnt;
	logic [3:0]           blocks_left;
	logic [11:0]          tag_q;
	logic                 finished;

	// --------------------------------------------------
	// Block sequencing
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			state       <= aux_tag;
			tag_cnt     <= 1'b0;
			smp_cnt     <= '0;
			blocks_left <= 4'd0;
			aux_wr_en   <= 1'b0;
			finished    <= 1'b0;
		end else begin
			aux_wr_en <= 1'b0;
			if (!pl.aux_on) begin
				state    <= aux_tag;
				tag_cnt  <= 1'b0;
				smp_cnt  <= '0;
				finished <= 1'b0;
			end else if (!finished) begin
				case (state)
					aux_tag: begin
						if (!tag_cnt) begin
							tag_cnt <= 1'b1;
						end else begin
							tag_cnt     <= 1'b0;
							blocks_left <= pl.byte_d[7:4];
							state       <= aux_samples;
						end
					end
					aux_samples: begin
						aux_wr_en <= 1'b1;
						if (smp_cnt == AUX_CNT_W'(AUX_SAMPLES - 1)) begin
							smp_cnt <= '0;
							state   <= aux_tag;
							// Last block, ignore the rest of the region
							if (blocks_left == 4'd1)
								finished <= 1'b1;
						end else begin
							smp_cnt <= smp_cnt + 1'b1;
						end
					end
					default: state <= aux_tag;
				endcase
			end
		end
	end

	// Tag bits and sample word
	always_ff @(posedge clk125) begin
		if (pl.aux_on && !finished) begin
			if (state == aux_tag && !tag_cnt)
				tag_q[7:0] <= pl.byte_d;
			if (state == aux_tag && tag_cnt)
				tag_q[11:8] <= pl.byte_d[3:0];
			if (state == aux_samples)
				aux_data_in <= {tag_q, 4'h0, pl.byte_d};
		end
	end

	assign aux_done = finished;

	// The filter closes the aux region once the last block is done
	a_done_closes_region: assert property (
		@(posedge clk125) disable iff (sys_rst)
		aux_done |=> !pl.aux_on
	);

endmodule

/* logic/gmii_video_rx.sv */
`timescale 1ns/1ps

module gmii_video_rx (
	input  logic       clk125,
	input  logic       sys_rst,
	input  logic       id,
	input  logic [7:0] rxd,
	input  logic       rx_dv,

	// Pixel FIFO write side
	output logic [vrx_pkg::VIDEO_WORD_W-1:0] datain,
	output logic       recv_en,
	output logic       packet_en,

	// Aux FIFO write side
	output logic [vrx_pkg::AUX_WORD_W-1:0]   aux_data_in,
	output logic       aux_wr_en
);

	vrx_payload_if pl ();

	logic aux_done;

	// --------------------------------------------------
	// Header check and region control
	// --------------------------------------------------
	udp_hdr_filter u_filter (
		.clk125    (clk125),
		.sys_rst   (sys_rst),
		.id        (id),
		.rx_dv     (rx_dv),
		.rxd       (rxd),
		.packet_en (packet_en),
		.pl        (pl),
		.aux_done  (aux_done)
	);

	// Pixel pairs
	video_word_packer u_packer (
		.clk125  (clk125),
		.sys_rst (sys_rst),
		.pl      (pl),
		.datain  (datain),
		.recv_en (recv_en)
	);

	// Aux samples
	aux_sample_unpacker u_unpacker (
		.clk125      (clk125),
		.sys_rst     (sys_rst),
		.pl          (pl),
		.aux_data_in (aux_data_in),
		.aux_wr_en   (aux_wr_en),
		.aux_done    (aux_done)
	);

endmodule

/* sim/vrx_checks.svh */
`ifndef VRX_CHECKS_SVH
`define VRX_CHECKS_SVH

task automatic stop_run();
	$display("Simulation failed");
	$fatal(1, "Stopped at first error");
endtask

task automatic report_problem(input string msg);
	$display("ERROR at %0t ns: %s", $time, msg);
	stop_run();
endtask

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_video_word(input logic [VIDEO_WORD_W-1:0] got,
		input logic [VIDEO_WORD_W-1:0] exp);
	if (got !== exp) begin
		$display("FAILED at %0t ns: video word %h, expected %h", $time, got, exp);
		stop_run();
	end
endtask

task automatic check_aux_word(input logic [AUX_WORD_W-1:0] got,
		input logic [AUX_WORD_W-1:0] exp);
	if (got !== exp) begin
		$display("FAILED at %0t ns: aux word %h, expected %h", $time, got, exp);
		stop_run();
	end
endtask

task automatic check_packet_en(input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED at %0t ns: packet_en %b, expected %b", $time, got, exp);
		stop_run();
	end
endtask

// --------------------------------------------------
// Reference model
// --------------------------------------------------
// Pairs start at byte 53, a pair cut by the frame end gives no word
task automatic expect_video(input int last);
	int k;
	logic x;
	logic [10:0] line;
	x = frame[OFS_LINE_HI][4];
	line = {frame[OFS_LINE_HI][2:0], frame[OFS_LINE_LO]};
	for (k = int'(OFS_LINE_HI) + 1; k + 1 <= last; k += 2)
		video_q.push_back({1'b0, x, line, frame[k], frame[k + 1]});
endtask

// Two tag bytes then AUX_SAMPLES samples per block
task automatic expect_aux(input int first, input int last);
	int k;
	int step;
	logic [11:0] tag;
	logic [3:0] left;
	logic done;
	step = 0;
	done = 1'b0;
	tag = '0;
	left = '0;
	for (k = first; k <= last && !done; k++) begin
		if (step == 0) begin
			tag[7:0] = frame[k];
		end else if (step == 1) begin
			tag[11:8] = frame[k][3:0];
			left = frame[k][7:4];
		end else begin
			aux_q.push_back({tag, 4'h0, frame[k]});
		end
		step++;
		if (step == AUX_SAMPLES + 2) begin
			step = 0;
			done = (left == 4'd1);
		end
	end
endtask

`endif

/* sim/gmii_video_rx_tb.sv */
`timescale 1ns/1ps

module gmii_video_rx_tb;
	import vrx_pkg::*;

	localparam int FRAME_LEN = 1400;
	localparam int DRAIN_LIMIT = 40;

	logic clk125;
	logic sys_rst;
	logic id;
	logic [7:0] rxd;
	logic rx_dv;
	logic [VIDEO_WORD_W-1:0] datain;
	logic recv_en;
	logic packet_en;
	logic [AUX_WORD_W-1:0] aux_data_in;
	logic aux_wr_en;

	logic [7:0] frame [0:FRAME_LEN-1];
	logic [VIDEO_WORD_W-1:0] video_q [$];
	logic [AUX_WORD_W-1:0] aux_q [$];
	integer seed = 99;
	// packet_en expected after the byte driven last
	logic pen_exp;

	`include "vrx_checks.svh"

	gmii_video_rx dut (
		.clk125      (clk125),
		.sys_rst     (sys_rst),
		.id          (id),
		.rxd         (rxd),
		.rx_dv       (rx_dv),
		.datain      (datain),
		.recv_en     (recv_en),
		.packet_en   (packet_en),
		.aux_data_in (aux_data_in),
		.aux_wr_en   (aux_wr_en)
	);

	initial begin
		clk125 = 1'b0;
		forever #4 clk125 = ~clk125;
	end

	// Strobes sampled mid-cycle
	always @(negedge clk125) begin
		if (!sys_rst && recv_en === 1'b1) begin
			if (video_q.size() == 0)
				report_problem("video word written with none expected");
			else
				check_video_word(datain, video_q.pop_front());
		end
		if (!sys_rst && aux_wr_en === 1'b1) begin
			if (aux_q.size() == 0)
				report_problem("aux word written with none expected");
			else
				check_aux_word(aux_data_in, aux_q.pop_front());
		end
	end

	// One GMII byte time
	task automatic drive_cycle(input logic dv, input logic [7:0] d, input logic pen_next);
		@(posedge clk125);
		#1;
		check_packet_en(packet_en, pen_exp);
		rx_dv = dv;
		rxd = d;
		pen_exp = pen_next;
	endtask

	task automatic place_aux_blocks(input int start, input logic [11:0] tag, input int blocks);
		int b;
		int base;
		logic [11:0] t;
		for (b = 0; b < blocks; b++) begin
			base = start + b * (AUX_SAMPLES + 2);
			t = tag + 12'(b);
			frame[base] = t[7:0];
			// High nibble counts the blocks left, down to 1
			frame[base + 1] = {4'(blocks - b), t[11:8]};
		end
	endtask

	// --------------------------------------------------
	// Frame builder and driver
	// --------------------------------------------------
	// Variant 1..5 spoils one field, 6 targets the other station, 7 and 8 cut the frame
	task automatic run_frame(input int variant, input logic sid, input pkt_kind_t kind,
			input logic [10:0] line, input logic [11:0] tag, input int blocks);
		int k;
		int rnd;
		int len;
		int waited;
		logic [31:0] dst;
		logic matched;
		logic opens_video;
		for (k = 0; k < FRAME_LEN; k++) begin
			rnd = $random(seed);
			frame[k] = rnd[7:0];
		end
		for (k = 0; k < 7; k++)
			frame[k] = 8'h55;
		frame[7] = 8'hd5;
		dst = IPV4_DST_BASE + {31'd0, sid};
		if (variant == 4)
			dst[15:8] = 8'd1;
		if (variant == 6)
			dst = IPV4_DST_BASE + {31'd0, ~sid};
		{frame[OFS_ETH_TYPE], frame[OFS_ETH_TYPE + 1]} = (variant == 1) ? 16'h86dd : ETH_TYPE_IPV4;
		frame[OFS_IP_VER] = (variant == 2) ? 8'h46 : IP_VER_IHL;
		frame[OFS_IP_PROTO] = (variant == 3) ? 8'h06 : IP_PROTO_UDP;
		{frame[OFS_IP_DST], frame[OFS_IP_DST + 1], frame[OFS_IP_DST + 2],
			frame[OFS_IP_DST + 3]} = dst;
		{frame[OFS_UDP_DST], frame[OFS_UDP_DST + 1]} =
			(variant == 5) ? UDP_DST_PORT + 16'd1 : UDP_DST_PORT;
		frame[OFS_INFO] = kind;
		if (kind == kind_audio) begin
			place_aux_blocks(OFS_LINE_LO, tag, blocks);
		end else begin
			frame[OFS_LINE_LO] = line[7:0];
			frame[OFS_LINE_HI][2:0] = line[10:8];
		end
		if (kind == kind_vidax)
			place_aux_blocks(OFS_VIDEO_END + 1, tag, blocks);

		len = (variant == 7) ? 700 : (variant == 8) ? 75 : FRAME_LEN;
		matched = (variant == 0 || variant == 7 || variant == 8);
		opens_video = matched && kind != kind_audio;
		if (opens_video)
			expect_video((len - 1 < int'(OFS_VIDEO_END)) ? len - 1 : int'(OFS_VIDEO_END));
		if (matched && kind == kind_audio)
			expect_aux(OFS_LINE_LO, len - 1);
		if (matched && kind == kind_vidax)
			expect_aux(OFS_VIDEO_END + 1,
				(len - 1 < int'(OFS_VIDAX_AUX_END) - 1) ? len - 1 : int'(OFS_VIDAX_AUX_END) - 1);

		id = sid;
		for (k = 0; k < len; k++)
			drive_cycle(1'b1, frame[k], opens_video && k >= OFS_INFO && k < OFS_VIDEO_END);

		// Let the last strobes come out
		waited = 0;
		while ((video_q.size() != 0 || aux_q.size() != 0) && waited < DRAIN_LIMIT) begin
			drive_cycle(1'b0, 8'h00, 1'b0);
			waited++;
		end
		if (video_q.size() != 0 || aux_q.size() != 0)
			report_problem($sformatf("timed out with %0d video and %0d aux words missing",
				video_q.size(), aux_q.size()));
		repeat (12) drive_cycle(1'b0, 8'h00, 1'b0);
	endtask

	initial begin
		int fd;
		int n;
		int nframes;
		int variant;
		int sid;
		int kind;
		int blocks;
		logic [10:0] line;
		logic [11:0] tag;
		string text;
		sys_rst = 1'b1;
		id = 1'b0;
		rx_dv = 1'b0;
		rxd = 8'h00;
		pen_exp = 1'b0;
		nframes = 0;
		repeat (16) @(posedge clk125);
		#1;
		sys_rst = 1'b0;

		fd = $fopen("sim/vrx_stimulus.txt", "r");
		if (fd == 0)
			report_problem("cannot open sim/vrx_stimulus.txt");
		while (!$feof(fd) && nframes < 64) begin
			n = $fgets(text, fd);
			if (n > 0 && text.getc(0) != "#") begin
				n = $sscanf(text, "%d %d %d %h %h %d", variant, sid, kind, line, tag, blocks);
				if (n == 6) begin
					run_frame(variant, sid[0], pkt_kind_t'(kind), line, tag, blocks);
					nframes++;
				end
			end
		end
		$fclose(fd);

		if (nframes == 0 || video_q.size() != 0 || aux_q.size() != 0) begin
			report_problem("no frames run or expected words left over");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

/* list.f */
+incdir+sim
logic/vrx_pkg.sv
logic/vrx_payload_if.sv
logic/udp_hdr_filter.sv
logic/video_word_packer.sv
logic/aux_sample_unpacker.sv
logic/gmii_video_rx.sv
sim/gmii_video_rx_tb.sv

/* sim/vrx_stimulus.txt */
# variant id kind line(hex) tag(hex) blocks
# variant 0 good, 1-5 one header field wrong, 6 other station, 7 cut at 700, 8 cut at 75
0 0 0 005 000 0
0 1 0 2a7 000 0
1 0 0 010 000 0
2 0 0 011 000 0
3 1 0 012 000 0
4 0 2 013 100 1
5 1 1 000 200 2
6 0 0 014 000 0
6 1 2 015 300 1
0 0 1 000 3a5 2
0 1 1 000 0ff 2
0 0 2 123 456 1
0 1 2 7ff fff 1
7 0 0 0c8 000 0
0 0 0 0c9 000 0
8 1 1 000 1b2 2
0 1 1 000 777 1
7 0 2 1f0 5a5 1
0 0 2 400 a5a 1
0 1 0 3ff 000 0
0 0 1 000 abc 3
1 1 2 020 000 1
3 0 1 000 123 2
0 1 2 001 800 1
0 0 0 000 000 0
